//--- tb/icache_stim.txt
// columns: op (0 fetch, 1 flush, 2 set enable, f end), address or enable value,
// expected miss, ack delay in cycles
0 00000104 1 2
0 00000100 0 0
0 00000108 0 0
0 0000010c 0 0
0 00000220 1 0
0 00000224 0 0
0 00001010 1 1
0 00001014 0 0
0 00002010 1 0
0 00002018 0 0
0 00003010 1 3
0 0000301c 0 0
0 00004010 1 0
0 00004014 0 0
0 00005010 1 2
0 00005018 0 0
0 00000100 0 0
1 00000000 0 0
0 00000100 1 1
0 00000104 0 0
2 00000000 0 0
0 00000100 1 0
0 00000100 1 1
0 00000108 1 0
2 00000001 0 0
0 00000100 1 0
0 00000104 0 0
0 00000340 1 0c
0 00000348 0 0
f 00000000 0 0

//--- compile.f
+incdir+common
common/icache_pkg.sv
common/icache_array_if.sv
icache/icache_ctrl.sv
icache/icache_repl.sv
icache/icache_arrays.sv
icache/icache_fetch_sel.sv
icache/icache_top.sv
tb/icache_tb.sv

//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - common

sources:
  - files:
      - common/icache_pkg.sv
      - common/icache_array_if.sv
      - icache/icache_ctrl.sv
      - icache/icache_repl.sv
      - icache/icache_arrays.sv
      - icache/icache_fetch_sel.sv
      - icache/icache_top.sv

  - target: test
    files:
      - tb/icache_tb.sv

//--- tb/icache_tb.sv
/*
 * instruction cache testbench
 * clock and reset, stimulus records from file, line memory model,
 * typed compare tasks, cycle limit and error summary
 */

`include "icache_defines.svh"

`default_nettype none

module icache_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned max_rec = 64;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    en_i;
  logic                    flush_i;
  logic                    miss_o;
  logic                    fetch_req_i;
  icache_pkg::paddr_t      fetch_addr_i;
  logic                    fetch_ready_o;
  logic                    fetch_valid_o;
  icache_pkg::fetch_word_t fetch_data_o;
  icache_pkg::paddr_t      fetch_addr_o;
  logic                    mem_req_o;
  icache_pkg::paddr_t      mem_addr_o;
  logic                    mem_ack_i;
  logic                    mem_rtrn_vld_i;
  icache_pkg::line_t       mem_rtrn_line_i;

  // four words per record: op, address, expected miss, ack delay
  logic [31:0] stim [4*max_rec];
  int unsigned n_rec;
  int unsigned n_err;        // wrong values
  int unsigned n_fail;       // missing responses and bad records
  int unsigned cycles = 0;
  int unsigned limit = 200;
  logic [31:0] rnd_state;
  logic        pre_acc;      // next fetch already taken back-to-back

  icache_top u_icache_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("errors: %0d value, %0d other", n_err, n_fail + 1);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // memory model and helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // each word holds its own byte address scrambled
  function automatic icache_pkg::fetch_word_t mem_word(input icache_pkg::paddr_t a);
    return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  function automatic icache_pkg::line_t mem_line(input icache_pkg::paddr_t a);
    icache_pkg::line_t l;
    for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
      l[w*32 +: 32] = mem_word({a[31:4], 4'h0} + icache_pkg::paddr_t'(4 * w));
    end
    return l;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_word(input string name, input icache_pkg::fetch_word_t exp,
                            input icache_pkg::fetch_word_t act);
    if (act !== exp) begin
      n_err++;
      $display("ERR %s exp %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_addr(input string name, input icache_pkg::paddr_t exp,
                            input icache_pkg::paddr_t act);
    if (act !== exp) begin
      n_err++;
      $display("ERR %s exp %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      n_err++;
      $display("ERR %s exp %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // ready low for n cycles, then high
  task automatic check_flush(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge clk_i);
      check_flag("fetch_ready_o", 1'b0, fetch_ready_o);
      next_cycle();
      flush_i = 1'b0;
    end
    @(negedge clk_i);
    check_flag("fetch_ready_o", 1'b1, fetch_ready_o);
    next_cycle();
  endtask

  task automatic fetch_and_check(input icache_pkg::paddr_t addr, input logic exp_miss,
                                 input int unsigned dly, input logic chain,
                                 input icache_pkg::paddr_t nxt);
    icache_pkg::paddr_t line_addr;
    int unsigned        gap;
    line_addr = {addr[31:4], 4'h0};
    if (!pre_acc) begin
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr;
      forever begin
        @(negedge clk_i);
        if (fetch_ready_o) break;
        next_cycle();
      end
      next_cycle();
    end
    fetch_req_i = 1'b0;
    pre_acc     = 1'b0;
    if (!exp_miss) begin
      // hit returns one cycle after acceptance, next fetch may go in now
      fetch_req_i  = chain;
      fetch_addr_i = nxt;
      @(negedge clk_i);
      if (!fetch_valid_o) begin
        n_fail++;
        $display("fetch of %h was expected to hit but returned no data", addr);
      end
      check_flag("mem_req_o", 1'b0, mem_req_o);
      check_word("fetch_data_o", mem_word(addr), fetch_data_o);
      check_addr("fetch_addr_o", addr, fetch_addr_o);
      if (chain) begin
        check_flag("fetch_ready_o", 1'b1, fetch_ready_o);
        pre_acc = 1'b1;
      end
      next_cycle();
      fetch_req_i = 1'b0;
    end else begin
      // request must hold steady until acknowledged
      for (int unsigned i = 0; i < dly; i++) begin
        @(negedge clk_i);
        check_flag("mem_req_o", 1'b1, mem_req_o);
        check_addr("mem_addr_o", line_addr, mem_addr_o);
        check_flag("fetch_ready_o", 1'b0, fetch_ready_o);
        check_flag("miss_o", 1'b0, miss_o);
        next_cycle();
      end
      mem_ack_i = 1'b1;
      @(negedge clk_i);
      check_flag("mem_req_o", 1'b1, mem_req_o);
      check_addr("mem_addr_o", line_addr, mem_addr_o);
      check_flag("miss_o", en_i, miss_o);
      next_cycle();
      mem_ack_i = 1'b0;
      // line returns one to three cycles after the ack
      rnd_state = xorshift(rnd_state);
      gap       = rnd_state % 3;
      repeat (gap) next_cycle();
      mem_rtrn_vld_i  = 1'b1;
      mem_rtrn_line_i = mem_line(addr);
      @(negedge clk_i);
      if (!fetch_valid_o) begin
        n_fail++;
        $display("fetch of %h got no data on the line return", addr);
      end
      check_flag("miss_o", 1'b0, miss_o);
      check_word("fetch_data_o", mem_word(addr), fetch_data_o);
      check_addr("fetch_addr_o", addr, fetch_addr_o);
      next_cycle();
      mem_rtrn_vld_i  = 1'b0;
      mem_rtrn_line_i = '0;
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : p_main
    logic [31:0] op;
    logic        chain;
    rst_ni          = 1'b0;
    en_i            = 1'b1;
    flush_i         = 1'b0;
    fetch_req_i     = 1'b0;
    fetch_addr_i    = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_line_i = '0;
    rnd_state       = 32'd12;
    pre_acc         = 1'b0;
    n_err           = 0;
    n_fail          = 0;
    n_rec           = 0;
    $readmemh("tb/icache_stim.txt", stim);
    // records end at op f or at the first unloaded entry
    while (n_rec < max_rec && !$isunknown(stim[4*n_rec]) && stim[4*n_rec] != 32'hF) begin
      n_rec++;
    end
    if (n_rec == 0) begin
      n_fail++;
      $display("no stimulus records could be read");
    end
    limit = 100 * n_rec + 200;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_flush(`ICACHE_SETS);
    for (int unsigned r = 0; r < n_rec; r++) begin
      op    = stim[4*r];
      chain = (r + 1 < n_rec) && (stim[4*r+4] == 32'h0) && (stim[4*r+6][0] == 1'b0);
      case (op)
        32'h0: fetch_and_check(stim[4*r+1], stim[4*r+2][0], stim[4*r+3], chain, stim[4*r+5]);
        // one cycle to see the request, then one per set
        32'h1: begin
          flush_i = 1'b1;
          check_flush(`ICACHE_SETS + 1);
        end
        32'h2: begin
          if (stim[4*r+1][0] && !en_i) begin
            en_i = 1'b1;
            check_flush(`ICACHE_SETS + 1);
          end else begin
            en_i = stim[4*r+1][0];
            next_cycle();
          end
        end
        default: begin
          n_fail++;
          $display("record %0d has an unknown operation %h", r, op);
        end
      endcase
    end
    $display("errors: %0d value, %0d other", n_err, n_fail);
    if (n_err == 0 && n_fail == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- icache/icache_top.sv
/*
 * instruction cache top
 * controller, replacement, arrays and fetch select around one array bus
 */

`default_nettype none

module icache_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    en_i,
  input  wire logic                    flush_i,
  output      logic                    miss_o,
  // fetch port
  input  wire logic                    fetch_req_i,
  input  wire icache_pkg::paddr_t      fetch_addr_i,
  output      logic                    fetch_ready_o,
  output      logic                    fetch_valid_o,
  output      icache_pkg::fetch_word_t fetch_data_o,
  output      icache_pkg::paddr_t      fetch_addr_o,
  // line refill port
  output      logic                    mem_req_o,
  output      icache_pkg::paddr_t      mem_addr_o,
  input  wire logic                    mem_ack_i,
  input  wire logic                    mem_rtrn_vld_i,
  input  wire icache_pkg::line_t       mem_rtrn_line_i
);

  logic                   hit;
  icache_pkg::way_oh_t    repl_way;
  logic                   all_valid;
  logic                   repl_adv;
  icache_pkg::tag_t       tag;
  icache_pkg::word_off_t  off;
  logic                   use_refill;

  icache_array_if u_arr_if ();

  icache_ctrl u_ctrl (
    .clk_i, .rst_ni, .en_i, .flush_i, .fetch_req_i, .fetch_addr_i,
    .hit_i           (hit),
    .repl_way_i      (repl_way),
    .all_valid_i     (all_valid),
    .mem_ack_i, .mem_rtrn_vld_i, .mem_rtrn_line_i,
    .fetch_ready_o, .fetch_valid_o, .miss_o, .fetch_addr_o,
    .tag_o           (tag),
    .off_o           (off),
    .use_refill_o    (use_refill),
    .repl_adv_o      (repl_adv),
    .mem_req_o, .mem_addr_o,
    .arr             (u_arr_if.ctrl)
  );

  icache_repl u_repl (
    .clk_i, .rst_ni,
    .repl_adv_i  (repl_adv),
    .repl_way_o  (repl_way),
    .all_valid_o (all_valid),
    .arr         (u_arr_if.sel)
  );

  icache_arrays u_arrays (.clk_i, .rst_ni, .arr (u_arr_if.array));

  // refill data comes straight from the return port
  icache_fetch_sel u_fetch_sel (
    .tag_i         (tag),
    .off_i         (off),
    .use_refill_i  (use_refill),
    .refill_line_i (mem_rtrn_line_i),
    .hit_o         (hit),
    .fetch_data_o,
    .arr           (u_arr_if.sel)
  );

endmodule

`default_nettype wire

//--- icache/icache_fetch_sel.sv
/*
 * tag compare and word select
 * per-way hit, priority hit way, word from hit line or refill line
 */

`include "icache_defines.svh"

`default_nettype none

module icache_fetch_sel (
  input  wire icache_pkg::tag_t       tag_i,
  input  wire icache_pkg::word_off_t  off_i,
  input  wire logic                   use_refill_i,
  input  wire icache_pkg::line_t      refill_line_i,
  output      logic                   hit_o,
  output      icache_pkg::fetch_word_t fetch_data_o,
  icache_array_if.sel                 arr
);

  localparam int unsigned word_w = $bits(icache_pkg::fetch_word_t);

  icache_pkg::way_oh_t  way_hit;
  icache_pkg::way_idx_t hit_idx;
  icache_pkg::line_t    src_line;

  // compare saved tag against every valid way
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_cmp
    assign way_hit[w] = arr.vld_rd[w] && (arr.tag_rd[w] == tag_i);
  end

  assign hit_o = |way_hit;

  // lowest hitting way
  always_comb begin : p_hit_idx
    hit_idx = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_idx = icache_pkg::way_idx_t'(w);
      end
    end
  end

  // refill line bypasses the array during the return beat
  assign src_line     = use_refill_i ? refill_line_i : arr.line_rd[hit_idx];
  assign fetch_data_o = src_line[int'(off_i) * word_w +: word_w];

  // a line is only ever allocated on a miss, so duplicates mean a broken refill
  a_hit_onehot0: assert final ($onehot0(way_hit));

endmodule

`default_nettype wire

//--- icache/icache_arrays.sv
/*
 * tag, valid and line storage for all ways
 * flip-flop arrays, registered read, per-set valid clear
 */

`include "icache_defines.svh"

`default_nettype none

module icache_arrays (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  icache_array_if.array  arr
);

  icache_pkg::tag_t  tag_mem  [`ICACHE_SETS][`ICACHE_WAYS];
  icache_pkg::line_t line_mem [`ICACHE_SETS][`ICACHE_WAYS];

  // valid bits, one way vector per set
  icache_pkg::way_oh_t [`ICACHE_SETS-1:0] vld_q;

  ////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld
    if (!rst_ni) begin
      vld_q      <= '0;
      arr.vld_rd <= '0;
    end else begin
      if (arr.vld_clr) begin
        vld_q[arr.idx] <= '0;
      end else if (arr.wr_en) begin
        vld_q[arr.idx] <= vld_q[arr.idx] | arr.wr_way_oh;
      end
      // read view of the set
      if (arr.rd_en) begin
        arr.vld_rd <= vld_q[arr.idx];
      end
    end
  end

  ////////////////////////////////////////
  // tags and lines
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin : p_mem
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      // refill lands in the chosen way only
      if (arr.wr_en && arr.wr_way_oh[w]) begin
        tag_mem[arr.idx][w]  <= arr.wr_tag;
        line_mem[arr.idx][w] <= arr.wr_line;
      end
      // all ways are read together
      if (arr.rd_en) begin
        arr.tag_rd[w]  <= tag_mem[arr.idx][w];
        arr.line_rd[w] <= line_mem[arr.idx][w];
      end
    end
  end

  a_wr_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr.wr_en |-> $onehot(arr.wr_way_oh));

endmodule

`default_nettype wire

//--- icache/icache_repl.sv
/*
 * replacement way choice
 * first invalid way, else an 8-bit LFSR pick once the set is full
 */

`include "icache_defines.svh"

`default_nettype none

module icache_repl (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 repl_adv_i,
  output      icache_pkg::way_oh_t  repl_way_o,
  output      logic                 all_valid_o,
  icache_array_if.sel               arr
);

  icache_pkg::way_oh_t       inv_way_oh;
  icache_pkg::way_idx_t      rnd_idx;
  logic [`ICACHE_LFSR_W-1:0] lfsr_d, lfsr_q;
  logic                      fb;

  // lowest numbered invalid way wins
  always_comb begin : p_first_inv
    inv_way_oh = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!arr.vld_rd[w]) begin
        inv_way_oh = icache_pkg::way_oh_t'(1) << w;
      end
    end
  end

  assign all_valid_o = &arr.vld_rd;

  // fibonacci form, x^8 + x^6 + x^5 + x^4 + 1
  assign fb     = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign lfsr_d = {lfsr_q[`ICACHE_LFSR_W-2:0], fb};

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q <= `ICACHE_LFSR_W'(1);
    end else if (repl_adv_i) begin
      lfsr_q <= lfsr_d;
    end
  end

  assign rnd_idx    = lfsr_q[$bits(icache_pkg::way_idx_t)-1:0];
  assign repl_way_o = all_valid_o ? (icache_pkg::way_oh_t'(1) << rnd_idx) : inv_way_oh;

  a_repl_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot(repl_way_o));

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
/*
 * instruction cache controller
 * latches and splits the fetch address, runs the FSM and the flush counter,
 * issues array reads, valid clears and refill writes, drives the line request
 */

`include "icache_defines.svh"

`default_nettype none

module icache_ctrl (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   en_i,
  input  wire logic                   flush_i,
  input  wire logic                   fetch_req_i,
  input  wire icache_pkg::paddr_t     fetch_addr_i,
  input  wire logic                   hit_i,
  input  wire icache_pkg::way_oh_t    repl_way_i,
  input  wire logic                   all_valid_i,
  input  wire logic                   mem_ack_i,
  input  wire logic                   mem_rtrn_vld_i,
  input  wire icache_pkg::line_t      mem_rtrn_line_i,
  output      logic                   fetch_ready_o,
  output      logic                   fetch_valid_o,
  output      logic                   miss_o,
  output      icache_pkg::paddr_t     fetch_addr_o,
  output      icache_pkg::tag_t       tag_o,
  output      icache_pkg::word_off_t  off_o,
  output      logic                   use_refill_o,
  output      logic                   repl_adv_o,
  output      logic                   mem_req_o,
  output      icache_pkg::paddr_t     mem_addr_o,
  icache_array_if.ctrl                arr
);

  // field positions inside the address
  localparam int unsigned off_lsb = $clog2($bits(icache_pkg::fetch_word_t) / 8);
  localparam int unsigned idx_lsb = off_lsb + $bits(icache_pkg::word_off_t);
  localparam int unsigned tag_lsb = idx_lsb + $bits(icache_pkg::set_idx_t);

  icache_pkg::ctrl_state_e state_d, state_q;
  logic                    flush_d, flush_q;   // flush waiting for the fetch to finish
  logic                    en_d, en_q;         // cache currently enabled
  icache_pkg::set_idx_t    cnt_d, cnt_q;       // set being cleared
  icache_pkg::paddr_t      addr_q;             // accepted fetch address
  icache_pkg::set_idx_t    idx_q;
  logic                    accept;

  ////////////////////////////////////////
  // address split
  ////////////////////////////////////////

  assign tag_o  = addr_q[tag_lsb +: $bits(icache_pkg::tag_t)];
  assign idx_q  = addr_q[idx_lsb +: $bits(icache_pkg::set_idx_t)];
  assign off_o  = addr_q[off_lsb +: $bits(icache_pkg::word_off_t)];

  // word aligned fetch address back to the core
  assign fetch_addr_o = {addr_q[$bits(icache_pkg::paddr_t)-1:off_lsb], {off_lsb{1'b0}}};
  // line aligned refill address, stable while in READ
  assign mem_addr_o   = {addr_q[$bits(icache_pkg::paddr_t)-1:idx_lsb], {idx_lsb{1'b0}}};

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin : p_fsm
    state_d       = state_q;
    en_d          = en_q & en_i;       // turning off is immediate, turning on goes via flush
    flush_d       = flush_q | flush_i;
    cnt_d         = cnt_q;
    accept        = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    arr.vld_clr   = 1'b0;
    arr.wr_en     = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      icache_pkg::FLUSH: begin
        arr.vld_clr = 1'b1;
        cnt_d       = cnt_q + 1'b1;
        if (cnt_q == icache_pkg::set_idx_t'(`ICACHE_SETS - 1)) begin
          state_d = icache_pkg::IDLE;
          flush_d = 1'b0;
          en_d    = en_i;
        end
      end
      // pending flush or a fresh enable go first
      icache_pkg::IDLE: begin
        if (flush_d || (en_i && !en_q)) begin
          state_d = icache_pkg::FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            accept  = 1'b1;
            state_d = icache_pkg::READ;
          end
        end
      end
      // lookup result, hit returns now and may take the next fetch
      icache_pkg::READ: begin
        if (hit_i && en_q) begin
          fetch_valid_o = 1'b1;
          state_d       = icache_pkg::IDLE;
          if (!flush_d) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              accept  = 1'b1;
              state_d = icache_pkg::READ;
            end
          end
        end else begin
          // miss or disabled, hold the request until taken
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = en_q;
            state_d = icache_pkg::MISS;
          end
        end
      end
      // line comes back in one beat, never stalled
      icache_pkg::MISS: begin
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          arr.wr_en     = en_q;
          state_d       = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////
  // array requests
  ////////////////////////////////////////

  assign arr.rd_en     = accept;
  assign arr.wr_way_oh = repl_way_i;
  assign arr.wr_tag    = tag_o;
  assign arr.wr_line   = mem_rtrn_line_i;

  // flush counter, then the new fetch, else the latched set for refill
  assign arr.idx = (state_q == icache_pkg::FLUSH) ? cnt_q :
                   accept ? fetch_addr_i[idx_lsb +: $bits(icache_pkg::set_idx_t)] : idx_q;

  assign use_refill_o = (state_q == icache_pkg::MISS);
  // LFSR only moves when a valid line gets evicted
  assign repl_adv_o   = arr.wr_en & all_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= icache_pkg::FLUSH;
      flush_q <= 1'b0;
      en_q    <= 1'b0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
      en_q    <= en_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_addr
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {icache_pkg::FLUSH, icache_pkg::IDLE, icache_pkg::READ, icache_pkg::MISS});

  a_wr_vs_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(arr.wr_en && arr.vld_clr));

  // a waiting request keeps its address until acknowledged
  a_mem_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o)));

endmodule

`default_nettype wire

//--- common/icache_array_if.sv
/*
 * array access bundle
 * read, write and valid-clear requests plus the registered read results
 */

`include "icache_defines.svh"

`default_nettype none

interface icache_array_if;

  // requests from the controller
  logic                                       rd_en;
  logic                                       wr_en;
  logic                                       vld_clr;
  icache_pkg::set_idx_t                       idx;
  icache_pkg::way_oh_t                        wr_way_oh;
  icache_pkg::tag_t                           wr_tag;
  icache_pkg::line_t                          wr_line;

  // read results, held until the next rd_en
  icache_pkg::tag_t  [`ICACHE_WAYS-1:0]       tag_rd;
  icache_pkg::way_oh_t                        vld_rd;
  icache_pkg::line_t [`ICACHE_WAYS-1:0]       line_rd;

  modport ctrl  (output rd_en, wr_en, vld_clr, idx, wr_way_oh, wr_tag, wr_line);
  modport array (input  rd_en, wr_en, vld_clr, idx, wr_way_oh, wr_tag, wr_line,
                 output tag_rd, vld_rd, line_rd);
  modport sel   (input  tag_rd, vld_rd, line_rd);

endinterface

`default_nettype wire

//--- common/icache_pkg.sv
/*
 * instruction cache types
 * address fields, line and word vectors, way vectors, controller states
 */

`include "icache_defines.svh"

`default_nettype none

package icache_pkg;

  // full physical address
  typedef logic [`ICACHE_PADDR_W-1:0] paddr_t;

  // address is split as tag | set index | word offset | byte offset
  typedef logic [`ICACHE_PADDR_W-$clog2(`ICACHE_SETS)-$clog2(`ICACHE_LINE_WORDS)-3:0] tag_t;
  typedef logic [$clog2(`ICACHE_SETS)-1:0] set_idx_t;
  typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] word_off_t;

  // payload
  typedef logic [31:0] fetch_word_t;
  typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;

  // way selection, one-hot and binary
  typedef logic [`ICACHE_WAYS-1:0] way_oh_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;

  // controller FSM
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- common/icache_defines.svh
/*
 * instruction cache geometry macros
 * ways, sets, words per line, address width and replacement LFSR width
 */

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// associativity, fixed by the one-hot way logic
`define ICACHE_WAYS 4

// number of sets, one flush cycle per set
`define ICACHE_SETS 16

// 32-bit words held by one line
`define ICACHE_LINE_WORDS 4

// physical fetch address width
`define ICACHE_PADDR_W 32

// replacement LFSR width, taps assume 8
`define ICACHE_LFSR_W 8

`endif
